/* hdl/ob_cfg_pkg.sv */
//////////////////////////////////////////////////
// Sizes of the order book fields and storage.
// Every width and depth in the design is taken
// from here through scoped names.
//////////////////////////////////////////////////

package ob_cfg_pkg;

  // Field widths of an order
  localparam int UID_W   = 8;
  localparam int PRICE_W = 16;
  localparam int QTY_W   = 12;

  // Resting orders held per side of the book
  localparam int TABLE_N = 8;

  // Width of a table's entry count, which must reach TABLE_N itself
  localparam int TABLE_CNT_W = $clog2(TABLE_N + 1);

  // Depth of the ingress and egress queues
  localparam int FIFO_N = 4;

endpackage

/* hdl/ob_pkg.sv */
//////////////////////////////////////////////////
// Command, response and resting entry types of
// the order book, with the response kind encoding.
//////////////////////////////////////////////////

package ob_pkg;

  typedef logic [ob_cfg_pkg::UID_W-1:0]   uid_t;
  typedef logic [ob_cfg_pkg::PRICE_W-1:0] price_t;
  typedef logic [ob_cfg_pkg::QTY_W-1:0]   qty_t;

  // Incoming limit order as it sits in the ingress queue
  typedef struct packed {
    logic   is_sell;
    uid_t   uid;
    price_t price;
    qty_t   qty;
  } cmd_t;

  // Order resting in a bid or ask table
  typedef struct packed {
    uid_t   uid;
    price_t price;
    qty_t   qty;
  } entry_t;

  typedef enum logic [1:0] {
    RSP_TRADE  = 2'd0,
    RSP_ADDED  = 2'd1,
    RSP_REJECT = 2'd2
  } rsp_kind_t;

  // The match_uid field names the resting order and is zero unless a trade
  typedef struct packed {
    rsp_kind_t kind;
    uid_t      uid;
    uid_t      match_uid;
    price_t    price;
    qty_t      qty;
  } rsp_t;

endpackage

/* hdl/ob_table_if.sv */
//////////////////////////////////////////////////
// Link between one price table and the match
// controller. The table takes modport tbl and the
// controller takes modport cntrl.
//////////////////////////////////////////////////

interface ob_table_if;

  // Head of the table, driven by the table
  logic           head_vld;
  ob_pkg::entry_t head;
  logic           full;

  // Operations from the controller, at most one per cycle
  logic           pop;
  logic           upd;
  ob_pkg::qty_t   upd_qty;
  logic           insert;
  ob_pkg::entry_t ins_entry;

  modport tbl (
    output head_vld, head, full,
    input  pop, upd, upd_qty, insert, ins_entry
  );

  modport cntrl (
    input  head_vld, head, full,
    output pop, upd, upd_qty, insert, ins_entry
  );

endinterface

/* hdl/ob_fifo.sv */
//////////////////////////////////////////////////
// Registered circular queue. Serves as the command
// ingress and the response egress of the book.
//////////////////////////////////////////////////

module ob_fifo #(
    parameter int W = 8
  , parameter int N = ob_cfg_pkg::FIFO_N
) (
    input  logic         clk
  , input  logic         rst_n
  , input  logic         push
  , input  logic [W-1:0] push_data
  , input  logic         pop
  , output logic [W-1:0] pop_data
  , output logic         empty
  , output logic         full
);

  logic [W-1:0]           mem [N];
  logic [$clog2(N)-1:0]   rd_ptr;
  logic [$clog2(N)-1:0]   wr_ptr;
  logic [$clog2(N+1)-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  // A pop frees a slot in the same cycle, so a full queue still takes a push
  assign do_pop   = pop & ~empty;
  assign do_push  = push & (~full | do_pop);

  assign empty    = (count == '0);
  assign full     = (count == N);
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == N - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == N - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hdl/ob_price_table.sv */
//////////////////////////////////////////////////
// One side of the book, kept sorted best first.
// Bids descend in price and asks ascend, and
// equal prices keep their arrival order.
//////////////////////////////////////////////////

module ob_price_table #(
    parameter bit IS_ASK = 1'b0
) (
    input logic       clk
  , input logic       rst_n
  , ob_table_if.tbl   tbl
);

  ob_pkg::entry_t                     entries  [ob_cfg_pkg::TABLE_N];
  ob_pkg::entry_t                     ins_next [ob_cfg_pkg::TABLE_N];
  logic [ob_cfg_pkg::TABLE_CNT_W-1:0] count;
  logic [ob_cfg_pkg::TABLE_N-1:0]     ahead;

  assign tbl.head_vld = (count != '0);
  assign tbl.head     = entries[0];
  assign tbl.full     = (count == ob_cfg_pkg::TABLE_N);

  // Valid entries priced better than or equal to the new one stay in front of it
  always_comb begin
    for (int i = 0; i < ob_cfg_pkg::TABLE_N; i++) begin
      if (IS_ASK) begin
        ahead[i] = (i < count) && (entries[i].price <= tbl.ins_entry.price);
      end else begin
        ahead[i] = (i < count) && (entries[i].price >= tbl.ins_entry.price);
      end
    end
  end

  // The table is sorted, so ahead is a run of ones from slot 0 and the new
  // entry lands in the first slot that is not ahead
  always_comb begin
    ins_next[0] = ahead[0] ? entries[0] : tbl.ins_entry;
    for (int i = 1; i < ob_cfg_pkg::TABLE_N; i++) begin
      if (ahead[i]) begin
        ins_next[i] = entries[i];
      end else if (ahead[i-1]) begin
        ins_next[i] = tbl.ins_entry;
      end else begin
        ins_next[i] = entries[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tbl.insert) begin
      for (int i = 0; i < ob_cfg_pkg::TABLE_N; i++) begin
        entries[i] <= ins_next[i];
      end
    end else if (tbl.pop) begin
      for (int i = 0; i < ob_cfg_pkg::TABLE_N - 1; i++) begin
        entries[i] <= entries[i+1];
      end
    end else if (tbl.upd) begin
      // Partial fill keeps the head in place with what is left of it
      entries[0].qty <= tbl.upd_qty;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (tbl.insert) begin
      count <= count + 1'b1;
    end else if (tbl.pop) begin
      count <= count - 1'b1;
    end
  end

endmodule

/* hdl/ob_match_cntrl.sv */
//////////////////////////////////////////////////
// Matching engine. Takes one command at a time,
// trades it against the opposite table head, and
// rests or rejects whatever quantity remains.
//////////////////////////////////////////////////

module ob_match_cntrl (
    input  logic         clk
  , input  logic         rst_n
  , input  logic         cmd_vld
  , input  ob_pkg::cmd_t cmd
  , input  logic         rsp_full
  , output logic         cmd_pop
  , output logic         rsp_push
  , output ob_pkg::rsp_t rsp
  , ob_table_if.cntrl    bid
  , ob_table_if.cntrl    ask
);

  typedef enum logic [1:0] {
    IDLE,
    MATCH,
    SETTLE
  } state_t;

  state_t         state;
  state_t         state_nxt;

  // Working order
  logic           work_is_sell;
  ob_pkg::uid_t   work_uid;
  ob_pkg::price_t work_price;
  ob_pkg::qty_t   rem_qty;

  logic           opp_vld;
  ob_pkg::entry_t opp_head;
  logic           own_full;
  logic           price_ok;
  logic           crosses;
  ob_pkg::qty_t   trade_qty;
  logic           head_done;
  logic           opp_pop;
  logic           opp_upd;
  logic           own_ins;
  logic           trade_fire;

  // A sell works against the bids and rests among the asks, a buy the reverse
  always_comb begin
    opp_vld  = work_is_sell ? bid.head_vld : ask.head_vld;
    opp_head = work_is_sell ? bid.head : ask.head;
    own_full = work_is_sell ? ask.full : bid.full;
    if (work_is_sell) begin
      price_ok = (opp_head.price >= work_price);
    end else begin
      price_ok = (opp_head.price <= work_price);
    end
    // A used up order stops matching even if the books still cross
    crosses   = opp_vld & price_ok & (rem_qty != '0);
    trade_qty = (rem_qty < opp_head.qty) ? rem_qty : opp_head.qty;
    head_done = (trade_qty == opp_head.qty);
  end

  always_comb begin
    state_nxt     = state;
    cmd_pop       = 1'b0;
    rsp_push      = 1'b0;
    opp_pop       = 1'b0;
    opp_upd       = 1'b0;
    own_ins       = 1'b0;
    trade_fire    = 1'b0;
    rsp.kind      = ob_pkg::RSP_ADDED;
    rsp.uid       = work_uid;
    rsp.match_uid = '0;
    rsp.price     = work_price;
    rsp.qty       = rem_qty;
    case (state)
      IDLE: begin
        if (cmd_vld) begin
          cmd_pop   = 1'b1;
          state_nxt = MATCH;
        end
      end
      MATCH: begin
        // Each branch that answers waits on a full egress queue
        if (crosses) begin
          if (!rsp_full) begin
            rsp_push      = 1'b1;
            trade_fire    = 1'b1;
            rsp.kind      = ob_pkg::RSP_TRADE;
            rsp.match_uid = opp_head.uid;
            rsp.price     = opp_head.price;
            rsp.qty       = trade_qty;
            opp_pop       = head_done;
            opp_upd       = ~head_done;
            state_nxt     = SETTLE;
          end
        end else if (rem_qty == '0) begin
          state_nxt = IDLE;
        end else if (!rsp_full) begin
          rsp_push  = 1'b1;
          state_nxt = IDLE;
          if (own_full) begin
            rsp.kind = ob_pkg::RSP_REJECT;
          end else begin
            own_ins = 1'b1;
          end
        end
      end
      // Gives the table a cycle to present its new head
      SETTLE:  state_nxt = MATCH;
      default: state_nxt = IDLE;
    endcase
  end

  assign bid.pop       = opp_pop & work_is_sell;
  assign ask.pop       = opp_pop & ~work_is_sell;
  assign bid.upd       = opp_upd & work_is_sell;
  assign ask.upd       = opp_upd & ~work_is_sell;
  assign bid.upd_qty   = opp_head.qty - trade_qty;
  assign ask.upd_qty   = opp_head.qty - trade_qty;
  assign bid.insert    = own_ins & ~work_is_sell;
  assign ask.insert    = own_ins & work_is_sell;
  assign bid.ins_entry = '{uid: work_uid, price: work_price, qty: rem_qty};
  assign ask.ins_entry = '{uid: work_uid, price: work_price, qty: rem_qty};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      work_is_sell <= cmd.is_sell;
      work_uid     <= cmd.uid;
      work_price   <= cmd.price;
      rem_qty      <= cmd.qty;
    end else if (trade_fire) begin
      rem_qty <= rem_qty - trade_qty;
    end
  end

endmodule

/* hdl/ob.sv */
//////////////////////////////////////////////////
// Order book top level. Commands enter through
// the ingress queue and every trade, added or
// reject response leaves through the egress queue.
//////////////////////////////////////////////////

module ob (
    input  logic                            clk
  , input  logic                            rst_n
  , input  logic                            cmd_vld
  , input  logic                            cmd_is_sell
  , input  logic [ob_cfg_pkg::UID_W-1:0]    cmd_uid
  , input  logic [ob_cfg_pkg::PRICE_W-1:0]  cmd_price
  , input  logic [ob_cfg_pkg::QTY_W-1:0]    cmd_qty
  , output logic                            cmd_full
  , input  logic                            rsp_accept
  , output logic                            rsp_vld
  , output ob_pkg::rsp_kind_t               rsp_kind
  , output logic [ob_cfg_pkg::UID_W-1:0]    rsp_uid
  , output logic [ob_cfg_pkg::UID_W-1:0]    rsp_match_uid
  , output logic [ob_cfg_pkg::PRICE_W-1:0]  rsp_price
  , output logic [ob_cfg_pkg::QTY_W-1:0]    rsp_qty
);

  ob_pkg::cmd_t cmd_in;
  ob_pkg::cmd_t cmd_head;
  logic         ingress_empty;
  logic         cntrl_cmd_pop;
  ob_pkg::rsp_t rsp_out;
  ob_pkg::rsp_t rsp_head;
  logic         cntrl_rsp_push;
  logic         egress_full;
  logic         egress_empty;

  ob_table_if bid_if ();
  ob_table_if ask_if ();

  assign cmd_in = '{is_sell: cmd_is_sell, uid: cmd_uid, price: cmd_price, qty: cmd_qty};

  ob_fifo #(.W($bits(ob_pkg::cmd_t))) u_ingress (
      .clk       (clk          )
    , .rst_n     (rst_n        )
    , .push      (cmd_vld      )
    , .push_data (cmd_in       )
    , .pop       (cntrl_cmd_pop)
    , .pop_data  (cmd_head     )
    , .empty     (ingress_empty)
    , .full      (cmd_full     )
  );

  ob_price_table #(.IS_ASK(1'b0)) u_bid_table (.clk(clk), .rst_n(rst_n), .tbl(bid_if));
  ob_price_table #(.IS_ASK(1'b1)) u_ask_table (.clk(clk), .rst_n(rst_n), .tbl(ask_if));

  ob_match_cntrl u_match_cntrl (
      .clk      (clk           )
    , .rst_n    (rst_n         )
    , .cmd_vld  (~ingress_empty)
    , .cmd      (cmd_head      )
    , .rsp_full (egress_full   )
    , .cmd_pop  (cntrl_cmd_pop )
    , .rsp_push (cntrl_rsp_push)
    , .rsp      (rsp_out       )
    , .bid      (bid_if        )
    , .ask      (ask_if        )
  );

  // The egress head stays put until accepted
  ob_fifo #(.W($bits(ob_pkg::rsp_t))) u_egress (
      .clk       (clk                   )
    , .rst_n     (rst_n                 )
    , .push      (cntrl_rsp_push        )
    , .push_data (rsp_out               )
    , .pop       (rsp_vld & rsp_accept  )
    , .pop_data  (rsp_head              )
    , .empty     (egress_empty          )
    , .full      (egress_full           )
  );

  assign rsp_vld       = ~egress_empty;
  assign rsp_kind      = rsp_head.kind;
  assign rsp_uid       = rsp_head.uid;
  assign rsp_match_uid = rsp_head.match_uid;
  assign rsp_price     = rsp_head.price;
  assign rsp_qty       = rsp_head.qty;

endmodule

/* testbench/ob_checker.sv */
//////////////////////////////////////////////////
// Concurrent assertions on the command and
// response handshakes of the order book.
// Attached to ob with bind.
//////////////////////////////////////////////////

module ob_checker (
    input logic                           clk
  , input logic                           rst_n
  , input logic                           cmd_vld
  , input logic                           cmd_full
  , input logic                           rsp_vld
  , input logic                           rsp_accept
  , input logic [1:0]                     rsp_kind
  , input logic [ob_cfg_pkg::UID_W-1:0]   rsp_uid
  , input logic [ob_cfg_pkg::UID_W-1:0]   rsp_match_uid
  , input logic [ob_cfg_pkg::PRICE_W-1:0] rsp_price
  , input logic [ob_cfg_pkg::QTY_W-1:0]   rsp_qty
);

  // Both queues are empty while reset is held
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !rsp_vld && !cmd_full)
    else $error("Response valid or ingress full raised during reset");

  push_when_full: assert property (@(posedge clk) disable iff (!rst_n) !(cmd_vld && cmd_full))
    else $error("Command pushed while the ingress queue was full");

  // A response that is not taken must stay exactly as it was
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_vld && !rsp_accept |=> rsp_vld &&
      $stable({rsp_kind, rsp_uid, rsp_match_uid, rsp_price, rsp_qty}))
    else $error("Response changed or vanished before it was accepted");

  kind_known: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_vld |-> rsp_kind inside {ob_pkg::RSP_TRADE, ob_pkg::RSP_ADDED, ob_pkg::RSP_REJECT})
    else $error("Response kind has an unknown encoding");

endmodule

bind ob ob_checker u_checker (
    .clk(clk), .rst_n(rst_n), .cmd_vld(cmd_vld), .cmd_full(cmd_full)
  , .rsp_vld(rsp_vld), .rsp_accept(rsp_accept), .rsp_kind(rsp_kind)
  , .rsp_uid(rsp_uid), .rsp_match_uid(rsp_match_uid)
  , .rsp_price(rsp_price), .rsp_qty(rsp_qty)
);

/* testbench/tb_ob.sv */
//////////////////////////////////////////////////
// Testbench for the order book. Sends directed and
// random limit orders, keeps a model of both sides
// and checks every response in order.
//////////////////////////////////////////////////

module tb_ob;

  localparam int N_RAND   = 200;
  localparam int N_CMD    = N_RAND + 11;
  localparam int PERIOD   = 40;
  localparam int WATCHDOG = (N_CMD * 40 + 500) * PERIOD;

  logic              clk;
  logic              rst_n;
  logic              cmd_vld;
  logic              cmd_is_sell;
  ob_pkg::uid_t      cmd_uid;
  ob_pkg::price_t    cmd_price;
  ob_pkg::qty_t      cmd_qty;
  logic              cmd_full;
  logic              rsp_accept;
  logic              rsp_vld;
  ob_pkg::rsp_kind_t rsp_kind;
  ob_pkg::uid_t      rsp_uid;
  ob_pkg::uid_t      rsp_match_uid;
  ob_pkg::price_t    rsp_price;
  ob_pkg::qty_t      rsp_qty;

  integer            seed;
  int                errors;
  int                next_uid;
  ob_pkg::entry_t    bids [$];
  ob_pkg::entry_t    asks [$];
  ob_pkg::rsp_t      exp_q [$];

  ob DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG);
    $display("Timeout after %0d time units with %0d responses missing", WATCHDOG, exp_q.size());
    $display("sim failed");
    $finish;
  end

  // The reference book trades best first, then rests or rejects the remainder
  task automatic apply_cmd(input logic is_sell, input ob_pkg::uid_t uid,
                           input ob_pkg::price_t price, input ob_pkg::qty_t qty);
    ob_pkg::entry_t opp [$];
    ob_pkg::entry_t own [$];
    ob_pkg::qty_t   fill;
    int             pos;
    if (is_sell) begin
      opp = bids;
      own = asks;
    end else begin
      opp = asks;
      own = bids;
    end
    while (qty != 0 && opp.size() != 0 &&
           (is_sell ? opp[0].price >= price : opp[0].price <= price)) begin
      fill = (qty < opp[0].qty) ? qty : opp[0].qty;
      exp_q.push_back(ob_pkg::rsp_t'{ob_pkg::RSP_TRADE, uid, opp[0].uid, opp[0].price, fill});
      qty = qty - fill;
      if (fill == opp[0].qty) begin
        void'(opp.pop_front());
      end else begin
        opp[0].qty = opp[0].qty - fill;
      end
    end
    if (qty != 0 && own.size() == ob_cfg_pkg::TABLE_N) begin
      exp_q.push_back(ob_pkg::rsp_t'{ob_pkg::RSP_REJECT, uid, ob_pkg::uid_t'(0), price, qty});
    end else if (qty != 0) begin
      // A new order goes behind every resting order of equal price
      pos = 0;
      while (pos < own.size() &&
             (is_sell ? own[pos].price <= price : own[pos].price >= price)) begin
        pos++;
      end
      own.insert(pos, ob_pkg::entry_t'{uid, price, qty});
      exp_q.push_back(ob_pkg::rsp_t'{ob_pkg::RSP_ADDED, uid, ob_pkg::uid_t'(0), price, qty});
    end
    if (is_sell) begin
      bids = opp;
      asks = own;
    end else begin
      bids = own;
      asks = opp;
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (exp_val == act_val) else begin
      errors++;
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_rsp();
    ob_pkg::rsp_t exp_rsp;
    assert (exp_q.size() != 0) else begin
      errors++;
      $display("A response for uid %0d came out when none was expected", rsp_uid);
    end
    if (exp_q.size() != 0) begin
      exp_rsp = exp_q.pop_front();
      check_field("rsp_kind", 32'(exp_rsp.kind), 32'(rsp_kind));
      check_field("rsp_uid", 32'(exp_rsp.uid), 32'(rsp_uid));
      check_field("rsp_match_uid", 32'(exp_rsp.match_uid), 32'(rsp_match_uid));
      check_field("rsp_price", 32'(exp_rsp.price), 32'(rsp_price));
      check_field("rsp_qty", 32'(exp_rsp.qty), 32'(rsp_qty));
    end
  endtask

  // Each falling edge draws rsp_accept and checks the response that leaves on the next rise
  task automatic tick();
    @(negedge clk);
    rsp_accept = (($random(seed) & 32'h7fff_ffff) % 10) < 7;
    if (rsp_vld && rsp_accept) begin
      check_rsp();
    end
  endtask

  task automatic send_cmd(input logic is_sell, input ob_pkg::price_t price,
                          input ob_pkg::qty_t qty);
    while (cmd_full) begin
      cmd_vld = 1'b0;
      tick();
    end
    cmd_vld     = 1'b1;
    cmd_is_sell = is_sell;
    cmd_uid     = ob_pkg::uid_t'(next_uid);
    cmd_price   = price;
    cmd_qty     = qty;
    apply_cmd(is_sell, cmd_uid, price, qty);
    next_uid++;
    tick();
  endtask

  initial begin
    logic           is_sell;
    ob_pkg::price_t price;
    ob_pkg::qty_t   qty;
    seed        = 55422;
    errors      = 0;
    next_uid    = 1;
    rst_n       = 1'b0;
    cmd_vld     = 1'b0;
    cmd_is_sell = 1'b0;
    cmd_uid     = '0;
    cmd_price   = '0;
    cmd_qty     = '0;
    rsp_accept  = 1'b0;
    repeat (4) @(negedge clk);
    assert (!rsp_vld && !cmd_full) else begin
      errors++;
      $display("Response valid or ingress full is high after reset");
    end
    rst_n = 1'b1;
    tick();
    // Ten buys below any ask fill the bid side and the last two are rejected
    for (int i = 0; i < 10; i++) begin
      send_cmd(1'b0, ob_pkg::price_t'(50 + i), ob_pkg::qty_t'(3));
    end
    // This sell sweeps exactly the eight stored bids
    send_cmd(1'b1, ob_pkg::price_t'(0), ob_pkg::qty_t'(24));
    for (int i = 0; i < N_RAND; i++) begin
      is_sell = 1'($random(seed) & 1);
      price   = ob_pkg::price_t'(100 + ($random(seed) & 7));
      qty     = ob_pkg::qty_t'(1 + ($random(seed) & 7));
      send_cmd(is_sell, price, qty);
    end
    cmd_vld = 1'b0;
    while (exp_q.size() != 0) begin
      tick();
    end
    repeat (20) tick();
    $display("Errors: %0d, responses still expected: %0d", errors, exp_q.size());
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* flist.f */
hdl/ob_cfg_pkg.sv
hdl/ob_pkg.sv
hdl/ob_table_if.sv
hdl/ob_fifo.sv
hdl/ob_price_table.sv
hdl/ob_match_cntrl.sv
hdl/ob.sv
testbench/ob_checker.sv
testbench/tb_ob.sv

/* run.sh */
#!/bin/sh
# Builds the order book testbench with Verilator, runs it and checks the log
set -e

verilator --binary --assert -Wno-fatal --top-module tb_ob -f flist.f

# A failed assertion may stop the run early, the log decides the result
./obj_dir/Vtb_ob > sim.log 2>&1 || true
cat sim.log

grep -qx "sim passed" sim.log
